//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 32;
    localparam int numRegs = 16;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [2*wordWidth-1:0] dwordT;
    typedef logic [3:0] regIdxT;
    typedef logic [4:0] opcodeT;
    typedef logic [1:0] condT;

    // IR field positions.
    localparam int opMsb = 31;
    localparam int opLsb = 27;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;
    localparam int constMsb = 18;
    localparam int condMsb = 20;
    localparam int condLsb = 19;

    // Opcodes; codes 0 to 2 and 15 are left free for memory and divide.
    localparam opcodeT opAdd = 5'd3;
    localparam opcodeT opSub = 5'd4;
    localparam opcodeT opAnd = 5'd5;
    localparam opcodeT opOr = 5'd6;
    localparam opcodeT opRor = 5'd7;
    localparam opcodeT opRol = 5'd8;
    localparam opcodeT opShr = 5'd9;
    localparam opcodeT opShra = 5'd10;
    localparam opcodeT opShl = 5'd11;
    localparam opcodeT opAddi = 5'd12;
    localparam opcodeT opAndi = 5'd13;
    localparam opcodeT opOri = 5'd14;
    localparam opcodeT opMul = 5'd16;
    localparam opcodeT opNeg = 5'd17;
    localparam opcodeT opNot = 5'd18;
    localparam opcodeT opBr = 5'd19;

    // Branch conditions in C2.
    localparam condT condZero = 2'd0;
    localparam condT condNonZero = 2'd1;
    localparam condT condPos = 2'd2;
    localparam condT condNeg = 2'd3;

    typedef struct packed {
        logic pcOut;
        logic zHighOut;
        logic zLowOut;
        logic mdrOut;
        logic hiOut;
        logic loOut;
        logic inPortOut;
        logic cOut;
        logic rOut;
        logic [numRegs-1:0] regOut;
    } busSrcT;

    typedef struct packed {
        logic pcIn;
        logic irIn;
        logic marIn;
        logic mdrIn;
        logic yIn;
        logic zIn;
        logic hiIn;
        logic loIn;
        logic outPortIn;
        logic conIn;
        logic rIn;
        logic [numRegs-1:0] regIn;
    } loadT;

    typedef struct packed {
        busSrcT busSrc;
        loadT load;
        logic gra;
        logic grb;
        logic grc;
        logic baOut;
        logic incPc;
        logic read;
    } ctrlT;

endpackage

`default_nettype wire

//--- hw/busMux.sv
`timescale 1ns/100ps
`default_nettype none

module busMux (
    input wire logic Clock,
    input wire logic rstN,
    input cpuPkg::busSrcT src,
    input cpuPkg::wordT regData,
    input cpuPkg::wordT pc,
    input cpuPkg::wordT zHigh,
    input cpuPkg::wordT zLow,
    input cpuPkg::wordT mdr,
    input cpuPkg::wordT hi,
    input cpuPkg::wordT lo,
    input cpuPkg::wordT inPort,
    input cpuPkg::wordT cSignExt,
    output cpuPkg::wordT busData
);

    logic regSel;

    // Register file drives the bus for Gr-selected or direct reads.
    assign regSel = src.rOut | (|src.regOut);

    // Strobes are one-hot, so a plain AND-OR needs no priority.
    assign busData = ({32{src.pcOut}} & pc)
                   | ({32{src.zHighOut}} & zHigh)
                   | ({32{src.zLowOut}} & zLow)
                   | ({32{src.mdrOut}} & mdr)
                   | ({32{src.hiOut}} & hi)
                   | ({32{src.loOut}} & lo)
                   | ({32{src.inPortOut}} & inPort)
                   | ({32{src.cOut}} & cSignExt)
                   | ({32{regSel}} & regData);

    // Two drivers in one step would OR their values onto the bus.
    busOneSource: assert property (
        @(posedge Clock) disable iff (!rstN)
        $onehot0({src.pcOut, src.zHighOut, src.zLowOut, src.mdrOut, src.hiOut,
                  src.loOut, src.inPortOut, src.cOut, src.rOut, src.regOut})
    ) else $error("busMux: more than one bus source in one step");

endmodule

`default_nettype wire

//--- hw/selectEncode.sv
`timescale 1ns/100ps
`default_nettype none

module selectEncode (
    input cpuPkg::wordT ir,
    input wire logic gra,
    input wire logic grb,
    input wire logic grc,
    input wire logic rIn,
    input wire logic rOut,
    input wire logic baOut,
    input wire logic [cpuPkg::numRegs-1:0] regIn,
    input wire logic [cpuPkg::numRegs-1:0] regOut,
    output logic [cpuPkg::numRegs-1:0] regWrEn,
    output logic [cpuPkg::numRegs-1:0] regRdSel,
    output logic readZero,
    output cpuPkg::wordT cSignExt
);

    import cpuPkg::*;

    regIdxT field;
    logic anySel;
    logic [numRegs-1:0] decoded;

    // Field select from IR.
    assign field = ({4{gra}} & ir[raMsb:raLsb])
                 | ({4{grb}} & ir[rbMsb:rbLsb])
                 | ({4{grc}} & ir[rcMsb:rcLsb]);

    assign anySel = gra | grb | grc;

    assign decoded = anySel ? ({{(numRegs-1){1'b0}}, 1'b1} << field) : '0;

    assign regWrEn = regIn | ({numRegs{rIn}} & decoded);

    // BAout reads the register like Rout does, with R0 as a zero base.
    assign regRdSel = regOut | ({numRegs{rOut | baOut}} & decoded);

    assign readZero = baOut & anySel & (field == '0);

    // Constant field sign-extended to a full word.
    assign cSignExt = {{(wordWidth-constMsb-1){ir[constMsb]}}, ir[constMsb:0]};

endmodule

`default_nettype wire

//--- regFile/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input wire logic Clock,
    input wire logic rstN,
    input cpuPkg::wordT busData,
    input wire logic [cpuPkg::numRegs-1:0] wrEn,
    input wire logic [cpuPkg::numRegs-1:0] rdSel,
    input wire logic readZero,
    output cpuPkg::wordT rdData
);

    import cpuPkg::*;

    wordT regs [numRegs];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (wrEn[i]) begin
                    regs[i] <= busData;
                end
            end
        end
    end

    // Read mux, one-hot select.
    always_comb begin
        rdData = '0;
        if (!readZero) begin
            for (int i = 0; i < numRegs; i++) begin
                if (rdSel[i]) begin
                    rdData = rdData | regs[i];
                end
            end
        end
    end

    // Gr decode and the direct vector must never pick two registers together.
    rdSelOneHot: assert property (
        @(posedge Clock) disable iff (!rstN)
        $onehot0(rdSel)
    ) else $error("regFile: read select 0x%h is not one-hot", rdSel);

endmodule

`default_nettype wire

//--- alu/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input cpuPkg::wordT y,
    input cpuPkg::wordT busData,
    input cpuPkg::opcodeT opcode,
    input wire logic incPc,
    output cpuPkg::dwordT result
);

    import cpuPkg::*;

    wordT low;
    logic [4:0] shamt;
    dwordT rotRight;
    dwordT rotLeft;
    logic signed [2*wordWidth-1:0] yWide;
    logic signed [2*wordWidth-1:0] bWide;
    logic signed [2*wordWidth-1:0] product;

    assign shamt = busData[4:0];

    // Rotates as shifts of the doubled word.
    assign rotRight = {y, y} >> shamt;
    assign rotLeft = {y, y} << shamt;

    assign yWide = {{wordWidth{y[wordWidth-1]}}, y};
    assign bWide = {{wordWidth{busData[wordWidth-1]}}, busData};
    assign product = yWide * bWide;

    always_comb begin
        low = '0;
        if (incPc) begin
            low = busData + wordT'(1);
        end else begin
            case (opcode)
                opAdd, opAddi, opBr: low = y + busData;
                opSub: low = y - busData;
                opAnd, opAndi: low = y & busData;
                opOr, opOri: low = y | busData;
                opShr: low = y >> shamt;
                opShra: low = wordT'($signed(y) >>> shamt);
                opShl: low = y << shamt;
                opRor: low = rotRight[wordWidth-1:0];
                opRol: low = rotLeft[2*wordWidth-1:wordWidth];
                // Unary ops act on the bus, Y is ignored.
                opNeg: low = wordT'(0) - busData;
                opNot: low = ~busData;
                default: low = '0;
            endcase
        end
    end

    // Only mul fills the high half.
    assign result = (!incPc && opcode == opMul) ? dwordT'(product)
                                                : {{wordWidth{1'b0}}, low};

endmodule

`default_nettype wire

//--- hw/conFf.sv
`timescale 1ns/100ps
`default_nettype none

module conFf (
    input wire logic Clock,
    input wire logic rstN,
    input wire logic conIn,
    input cpuPkg::wordT ir,
    input cpuPkg::wordT busData,
    output logic conFlag
);

    import cpuPkg::*;

    condT cond;
    logic isZero;
    logic hit;

    assign cond = ir[condMsb:condLsb];
    assign isZero = (busData == '0);

    // Positive means strictly above zero.
    always_comb begin
        case (cond)
            condZero: hit = isZero;
            condNonZero: hit = !isZero;
            condPos: hit = !busData[wordWidth-1] && !isZero;
            condNeg: hit = busData[wordWidth-1];
            default: hit = 1'b0;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            conFlag <= 1'b0;
        end else if (conIn) begin
            conFlag <= hit;
        end
    end

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath (
    input wire logic Clock,
    input wire logic rstN,
    input cpuPkg::ctrlT ctrl,
    input cpuPkg::wordT mdataIn,
    input cpuPkg::wordT inPort,
    output cpuPkg::wordT memAddr,
    output cpuPkg::wordT mdrData,
    output cpuPkg::wordT outPort,
    output logic conFlag
);

    import cpuPkg::*;

    wordT busData;
    wordT pc;
    wordT ir;
    wordT mar;
    wordT mdr;
    wordT y;
    dwordT z;
    wordT hi;
    wordT lo;
    wordT inPortReg;
    wordT outPortReg;
    dwordT aluResult;
    wordT regData;
    wordT cSignExt;
    logic [numRegs-1:0] regWrEn;
    logic [numRegs-1:0] regRdSel;
    logic readZero;
    busSrcT muxSrc;

    // BAout puts the register file on the bus just like Rout.
    always_comb begin
        muxSrc = ctrl.busSrc;
        muxSrc.rOut = ctrl.busSrc.rOut | ctrl.baOut;
    end

    busMux busMux0 (
        .Clock(Clock),
        .rstN(rstN),
        .src(muxSrc),
        .regData(regData),
        .pc(pc),
        .zHigh(z[2*wordWidth-1:wordWidth]),
        .zLow(z[wordWidth-1:0]),
        .mdr(mdr),
        .hi(hi),
        .lo(lo),
        .inPort(inPortReg),
        .cSignExt(cSignExt),
        .busData(busData)
    );

    selectEncode selectEncode0 (
        .ir(ir),
        .gra(ctrl.gra),
        .grb(ctrl.grb),
        .grc(ctrl.grc),
        .rIn(ctrl.load.rIn),
        .rOut(ctrl.busSrc.rOut),
        .baOut(ctrl.baOut),
        .regIn(ctrl.load.regIn),
        .regOut(ctrl.busSrc.regOut),
        .regWrEn(regWrEn),
        .regRdSel(regRdSel),
        .readZero(readZero),
        .cSignExt(cSignExt)
    );

    regFile regFile0 (
        .Clock(Clock),
        .rstN(rstN),
        .busData(busData),
        .wrEn(regWrEn),
        .rdSel(regRdSel),
        .readZero(readZero),
        .rdData(regData)
    );

    alu alu0 (
        .y(y),
        .busData(busData),
        .opcode(ir[opMsb:opLsb]),
        .incPc(ctrl.incPc),
        .result(aluResult)
    );

    conFf conFf0 (
        .Clock(Clock),
        .rstN(rstN),
        .conIn(ctrl.load.conIn),
        .ir(ir),
        .busData(busData),
        .conFlag(conFlag)
    );

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
            mar <= '0;
            mdr <= '0;
            y <= '0;
            z <= '0;
            hi <= '0;
            lo <= '0;
            inPortReg <= '0;
            outPortReg <= '0;
        end else begin
            if (ctrl.load.pcIn) pc <= busData;
            if (ctrl.load.irIn) ir <= busData;
            if (ctrl.load.marIn) mar <= busData;
            // Memory data or the bus.
            if (ctrl.load.mdrIn) mdr <= ctrl.read ? mdataIn : busData;
            if (ctrl.load.yIn) y <= busData;
            if (ctrl.load.zIn) z <= aluResult;
            if (ctrl.load.hiIn) hi <= busData;
            if (ctrl.load.loIn) lo <= busData;
            if (ctrl.load.outPortIn) outPortReg <= busData;
            inPortReg <= inPort;
        end
    end

    assign memAddr = mar;
    assign mdrData = mdr;
    assign outPort = outPortReg;

    // One IR field per step, or the decoded register would be a blend.
    grOneField: assert property (
        @(posedge Clock) disable iff (!rstN)
        $onehot0({ctrl.gra, ctrl.grb, ctrl.grc})
    ) else $error("datapath: more than one of Gra, Grb, Grc in one step");

endmodule

`default_nettype wire

//--- testbench/datapathTb.sv
`timescale 1ns/100ps
`default_nettype none

module datapathTb;

    import cpuPkg::*;

    localparam int resetCycles = 16;
    localparam int numTests = 6;
    localparam int stepsPerTest = 40;
    localparam int randomOps = 40;
    localparam int stepsPerRandomOp = 10;
    // Twice the steps that the whole run needs.
    localparam int maxCycles = 2 * (resetCycles + numTests * stepsPerTest
                                    + randomOps * stepsPerRandomOp);
    localparam opcodeT aluOps [11] = '{opAdd, opSub, opAnd, opOr, opShr, opShra,
                                       opShl, opRor, opRol, opNeg, opNot};

    logic Clock;
    logic rstN;
    ctrlT ctrl;
    wordT mdataIn;
    wordT inPort;
    wordT memAddr;
    wordT mdrData;
    wordT outPort;
    logic conFlag;

    // Step being built, and the step of the previous cycle for the checks.
    ctrlT c;
    wordT want;
    ctrlT ctrlQ;
    wordT wantQ;

    wordT shadow [numRegs];
    wordT pcModel;
    wordT hiModel;
    wordT loModel;
    int cycles;
    int checks;
    int errors;
    int errorsBefore;
    int tests;

    datapath dut0 (
        .Clock(Clock),
        .rstN(rstN),
        .ctrl(ctrl),
        .mdataIn(mdataIn),
        .inPort(inPort),
        .memAddr(memAddr),
        .mdrData(mdrData),
        .outPort(outPort),
        .conFlag(conFlag)
    );

    always #20 Clock = ~Clock;

    function automatic wordT makeInstr(input opcodeT op, input regIdxT ra, input regIdxT rb,
                                       input logic [18:0] low);
        return {op, ra, rb, low};
    endfunction

    // Unary ops take the bus operand b.
    function automatic wordT modelOp(input opcodeT op, input wordT a, input wordT b);
        int s;
        s = int'(b[4:0]);
        case (op)
            opAdd: return a + b;
            opSub: return a - b;
            opAnd: return a & b;
            opOr: return a | b;
            opShr: return a >> s;
            opShra: return wordT'(signed'(a) >>> s);
            opShl: return a << s;
            opRor: return (a >> s) | (a << (32 - s));
            opRol: return (a << s) | (a >> (32 - s));
            opNeg: return ~b + 32'd1;
            opNot: return ~b;
            default: return '0;
        endcase
    endfunction

    function automatic logic condHolds(input condT cond, input wordT v);
        case (cond)
            condZero: return v == 0;
            condNonZero: return v != 0;
            condPos: return signed'(v) > 0;
            default: return signed'(v) < 0;
        endcase
    endfunction

    task automatic go(input wordT data, input wordT expected);
        @(posedge Clock);
        ctrl <= c;
        mdataIn <= data;
        want <= expected;
        checks += int'(c.load.outPortIn | c.load.marIn | c.load.conIn | c.load.mdrIn);
        c = '0;
    endtask

    // Word through MDR onto the bus, into the loads staged in c.
    task automatic fromMemory(input wordT value, input wordT expected);
        ctrlT dest;
        dest = c;
        c = '0;
        c.read = 1'b1;
        c.load.mdrIn = 1'b1;
        go(value, value);
        c = dest;
        c.busSrc.mdrOut = 1'b1;
        go('0, expected);
    endtask

    task automatic writeReg(input regIdxT idx, input wordT value);
        c.load.regIn[idx] = 1'b1;
        fromMemory(value, '0);
        shadow[idx] = value;
    endtask

    task automatic loadIr(input wordT instr);
        c.load.irIn = 1'b1;
        fromMemory(instr, '0);
    endtask

    task automatic showReg(input regIdxT idx);
        c.busSrc.regOut[idx] = 1'b1;
        c.load.outPortIn = 1'b1;
        go('0, shadow[idx]);
    endtask

    // The in-port register takes inPort at the edge after it is driven.
    task automatic showInPort(input wordT value);
        inPort <= value;
        c.busSrc.inPortOut = 1'b1;
        c.load.outPortIn = 1'b1;
        go('0, value);
    endtask

    // Y from Rb, Z from Rc or the constant, then Z low back to Ra.
    task automatic execute(input logic useConst);
        c.grb = 1'b1;
        c.busSrc.rOut = 1'b1;
        c.load.yIn = 1'b1;
        go('0, '0);
        c.grc = !useConst;
        c.busSrc.rOut = !useConst;
        c.busSrc.cOut = useConst;
        c.load.zIn = 1'b1;
        go('0, '0);
        c.busSrc.zLowOut = 1'b1;
        c.gra = 1'b1;
        c.load.rIn = 1'b1;
        go('0, '0);
    endtask

    task automatic report(input string name);
        // Lets the last check fire first.
        repeat (3) go('0, '0);
        $display("Test %s finished with %0d errors", name, errors - errorsBefore);
        errorsBefore = errors;
        tests++;
    endtask

    task automatic testOri();
        writeReg(4'd3, $urandom);
        loadIr(makeInstr(opOri, 4'd2, 4'd3, 19'h25));
        execute(1'b1);
        shadow[2] = shadow[3] | 32'h25;
        showReg(4'd2);
        showInPort($urandom);
    endtask

    task automatic testRandomOps();
        opcodeT op;
        regIdxT ra;
        regIdxT rb;
        regIdxT rc;
        logic [3:0] k;
        for (int i = 0; i < randomOps; i++) begin
            k = 4'($urandom % 11);
            op = aluOps[k];
            ra = regIdxT'($urandom);
            rb = regIdxT'($urandom);
            rc = regIdxT'($urandom);
            writeReg(rb, $urandom);
            writeReg(rc, $urandom);
            loadIr(makeInstr(op, ra, rb, {rc, 15'd0}));
            execute(1'b0);
            shadow[ra] = modelOp(op, shadow[rb], shadow[rc]);
            showReg(ra);
        end
    endtask

    task automatic testMul();
        longint product;
        writeReg(4'd6, $urandom);
        writeReg(4'd7, $urandom);
        loadIr(makeInstr(opMul, 4'd8, 4'd6, {4'd7, 15'd0}));
        execute(1'b0);
        product = longint'(signed'(shadow[6])) * longint'(signed'(shadow[7]));
        shadow[8] = product[31:0];
        loModel = product[31:0];
        hiModel = product[63:32];
        c.busSrc.zLowOut = 1'b1;
        c.load.loIn = 1'b1;
        go('0, '0);
        c.busSrc.zHighOut = 1'b1;
        c.load.hiIn = 1'b1;
        go('0, '0);
        c.busSrc.loOut = 1'b1;
        c.load.outPortIn = 1'b1;
        go('0, loModel);
        c.busSrc.hiOut = 1'b1;
        c.load.outPortIn = 1'b1;
        go('0, hiModel);
    endtask

    task automatic testBaseZero();
        logic [18:0] imm;
        imm = 19'($urandom);
        writeReg(4'd0, $urandom | 32'd1);
        loadIr(makeInstr(opAddi, 4'd0, 4'd0, imm));
        // R0 reads as zero, so Z gets the constant alone.
        c.gra = 1'b1;
        c.baOut = 1'b1;
        c.load.yIn = 1'b1;
        go('0, '0);
        c.busSrc.cOut = 1'b1;
        c.load.zIn = 1'b1;
        go('0, '0);
        c.busSrc.zLowOut = 1'b1;
        c.load.outPortIn = 1'b1;
        go('0, {{13{imm[18]}}, imm});
        c.gra = 1'b1;
        c.busSrc.rOut = 1'b1;
        c.load.outPortIn = 1'b1;
        go('0, shadow[0]);
    endtask

    task automatic testFetch();
        for (int i = 0; i < 6; i++) begin
            c.busSrc.pcOut = 1'b1;
            c.load.marIn = 1'b1;
            c.incPc = 1'b1;
            c.load.zIn = 1'b1;
            go('0, pcModel);
            c.busSrc.zLowOut = 1'b1;
            c.load.pcIn = 1'b1;
            go('0, '0);
            pcModel++;
        end
    endtask

    task automatic testBranch();
        condT cond;
        wordT value;
        for (int k = 0; k < 4; k++) begin
            cond = condT'(k);
            loadIr(makeInstr(opBr, 4'd0, {2'b00, cond}, '0));
            for (int j = 0; j < 3; j++) begin
                case (j)
                    0: value = '0;
                    1: value = {1'b0, 31'($urandom)} | 32'd1;
                    default: value = {1'b1, 31'($urandom)};
                endcase
                c.load.conIn = 1'b1;
                fromMemory(value, wordT'(condHolds(cond, value)));
            end
        end
    endtask

    always @(posedge Clock) begin
        ctrlQ <= ctrl;
        wantQ <= want;
    end

    outPortCheck: assert property (@(posedge Clock) disable iff (!rstN)
        ctrlQ.load.outPortIn |-> outPort == wantQ)
    else begin
        errors++;
        $display("MISMATCH at %0t: outPort 0x%h, expected 0x%h", $time, outPort, wantQ);
    end

    memAddrCheck: assert property (@(posedge Clock) disable iff (!rstN)
        ctrlQ.load.marIn |-> memAddr == wantQ)
    else begin
        errors++;
        $display("MISMATCH at %0t: memAddr 0x%h, expected 0x%h", $time, memAddr, wantQ);
    end

    mdrDataCheck: assert property (@(posedge Clock) disable iff (!rstN)
        ctrlQ.load.mdrIn |-> mdrData == wantQ)
    else begin
        errors++;
        $display("MISMATCH at %0t: mdrData 0x%h, expected 0x%h", $time, mdrData, wantQ);
    end

    conFlagCheck: assert property (@(posedge Clock) disable iff (!rstN)
        ctrlQ.load.conIn |-> conFlag == wantQ[0])
    else begin
        errors++;
        $display("MISMATCH at %0t: conFlag %b, expected %b", $time, conFlag, wantQ[0]);
    end

    always @(posedge Clock) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("Timeout: run did not finish within %0d cycles", maxCycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        Clock = 1'b0;
        rstN = 1'b0;
        ctrl = '0;
        mdataIn = '0;
        inPort = '0;
        c = '0;
        want = '0;
        pcModel = '0;
        hiModel = '0;
        loModel = '0;
        cycles = 0;
        checks = 0;
        errors = 0;
        errorsBefore = 0;
        tests = 0;
        void'($urandom(5));
        for (int i = 0; i < numRegs; i++) begin
            shadow[i] = '0;
        end
        repeat (resetCycles) @(posedge Clock);
        rstN <= 1'b1;
        testOri();
        report("register load, ori and in-port");
        testRandomOps();
        report("random register operations");
        testMul();
        report("multiply through HI and LO");
        testBaseZero();
        report("R0 under BAout");
        testFetch();
        report("PC fetch steps");
        testBranch();
        report("branch conditions");
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/cpuPkg.sv
hw/busMux.sv
hw/selectEncode.sv
regFile/regFile.sv
alu/alu.sv
hw/conFf.sv
hw/datapath.sv
testbench/datapathTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= datapathTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$($(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
